//--- hw/bank_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module bank_tracker (
  input  wire      clk_i,
  input  wire      rst_ni,
  bank_if.tracker  bank
);
  import sdram_geom_pkg::*;
  import sdram_timing_pkg::*;

  logic [BANKS-1:0]     act_sel;
  logic [BANKS-1:0]     pre_sel;
  logic [TCNT_BITS-1:0] rcd_cnt [BANKS];
  logic [TCNT_BITS-1:0] ras_cnt [BANKS];
  logic [TCNT_BITS-1:0] rp_cnt  [BANKS];

  // Load on command, else count down and stop at zero
  function automatic logic [TCNT_BITS-1:0] tick(input logic                 load,
                                                input logic [TCNT_BITS-1:0] val,
                                                input logic [TCNT_BITS-1:0] cnt);
    if (load)
      return val;
    else if (cnt != '0)
      return cnt - 1'b1;
    else
      return cnt;
  endfunction

  // Strobes decoded per bank
  assign act_sel = bank.act ? (BANKS'(1) << bank.ba) : '0;
  assign pre_sel = bank.pre_all ? '1 : (bank.pre ? (BANKS'(1) << bank.ba) : '0);

  ////////////////////////////////////////////////////////////////////////////
  // Bank state and timers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      bank.open <= '0;
      for (int b = 0; b < BANKS; b++)
      begin
        rcd_cnt[b] <= '0;
        ras_cnt[b] <= '0;
        rp_cnt[b]  <= '0;
      end
    end
    else
    begin
      bank.open <= (bank.open & ~pre_sel) | act_sel;
      for (int b = 0; b < BANKS; b++)
      begin
        rcd_cnt[b] <= tick(act_sel[b], TCNT_BITS'(T_RCD), rcd_cnt[b]);
        ras_cnt[b] <= tick(act_sel[b], TCNT_BITS'(T_RAS), ras_cnt[b]);
        rp_cnt[b]  <= tick(pre_sel[b], TCNT_BITS'(T_RP), rp_cnt[b]);
      end
    end
  end

  // Row captured at ACT, only meaningful while open
  always_ff @(posedge clk_i)
  begin
    for (int b = 0; b < BANKS; b++)
      if (act_sel[b])
        bank.open_row[b] <= bank.row;
  end

  always_comb
  begin
    for (int b = 0; b < BANKS; b++)
    begin
      bank.act_ok[b] = (rp_cnt[b] == '0);
      bank.rw_ok[b]  = (rcd_cnt[b] == '0);
      bank.pre_ok[b] = (ras_cnt[b] == '0);
    end
  end

endmodule : bank_tracker

`default_nettype wire

//--- hw/cmd_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_sequencer (
  input  wire                                   clk_i,
  input  wire                                   rst_ni,
  sched_req_if.sequencer                        req,
  bank_if.sequencer                             bank,
  input  wire                                   ref_due_i,
  input  wire                                   ref_urgent_i,
  input  wire                                   rfc_ok_i,
  output logic                                  ref_issue_o,
  output logic                                  rd_issue_o,
  output logic [sdram_geom_pkg::PORT_BITS-1:0]  rd_port_o,
  output sdram_geom_pkg::sdram_cmd_t            sdram_cmd_o,
  output logic [sdram_geom_pkg::BA_BITS-1:0]    sdram_ba_o,
  output logic [sdram_geom_pkg::ADDR_BITS-1:0]  sdram_addr_o,
  output logic [sdram_geom_pkg::DQ_BITS-1:0]    sdram_dq_o,
  output logic                                  sdram_dqoe_o
);
  import sdram_geom_pkg::*;

  typedef enum logic {
    IDLE    = 1'b0,
    REFRESH = 1'b1
  } state_t;

  state_t               state;
  state_t               nxt_state;
  sdram_cmd_t           nxt_cmd;
  logic [ADDR_BITS-1:0] nxt_addr;
  logic                 all_idle;
  logic                 all_act_ok;
  logic                 row_hit;

  assign all_idle   = ~|bank.open;
  assign all_act_ok = &bank.act_ok;
  assign row_hit    = bank.open[req.ba] && (bank.open_row[req.ba] == req.row);

  // Bank address and row always follow the selected request
  assign bank.ba   = req.ba;
  assign bank.row  = req.row;
  assign rd_port_o = req.port;

  ////////////////////////////////////////////////////////////////////////////
  // Command decision
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    nxt_state    = state;
    nxt_cmd      = CMD_NOP;
    nxt_addr     = '0;
    bank.act     = 1'b0;
    bank.pre     = 1'b0;
    bank.pre_all = 1'b0;
    req.issue    = 1'b0;
    ref_issue_o  = 1'b0;
    rd_issue_o   = 1'b0;

    case (state)
      IDLE:
        if (ref_urgent_i || (ref_due_i && !req.valid))
        begin
          // Close everything first, then refresh
          if (all_idle)
          begin
            if (all_act_ok && rfc_ok_i)
            begin
              nxt_cmd     = CMD_REF;
              ref_issue_o = 1'b1;
            end
          end
          else if (&bank.pre_ok)
          begin
            nxt_cmd          = CMD_PRE;
            nxt_addr[AP_BIT] = 1'b1;
            bank.pre_all     = 1'b1;
            nxt_state        = REFRESH;
          end
        end
        else if (req.valid && rfc_ok_i)
        begin
          if (row_hit)
          begin
            if (bank.rw_ok[req.ba])
            begin
              nxt_cmd    = req.we ? CMD_WR : CMD_RD;
              nxt_addr   = ADDR_BITS'(req.col);
              req.issue  = 1'b1;
              rd_issue_o = !req.we;
            end
          end
          else if (!bank.open[req.ba])
          begin
            if (bank.act_ok[req.ba])
            begin
              nxt_cmd  = CMD_ACT;
              nxt_addr = req.row;
              bank.act = 1'b1;
            end
          end
          else if (bank.pre_ok[req.ba])
          begin
            // Wrong row open, single bank precharge
            nxt_cmd  = CMD_PRE;
            bank.pre = 1'b1;
          end
        end

      REFRESH:
        if (all_act_ok && rfc_ok_i)
        begin
          nxt_cmd     = CMD_REF;
          ref_issue_o = 1'b1;
          nxt_state   = IDLE;
        end

      default: nxt_state = IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registered SDRAM outputs
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state        <= IDLE;
      sdram_cmd_o  <= CMD_NOP;
      sdram_dqoe_o <= 1'b0;
    end
    else
    begin
      state        <= nxt_state;
      sdram_cmd_o  <= nxt_cmd;
      sdram_dqoe_o <= (nxt_cmd == CMD_WR);
    end
  end

  always_ff @(posedge clk_i)
  begin
    sdram_ba_o   <= req.ba;
    sdram_addr_o <= nxt_addr;
    sdram_dq_o   <= req.wdata;   // valid whenever dqoe is set
  end

endmodule : cmd_sequencer

`default_nettype wire

//--- hw/port_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module port_arbiter (
  input  wire                                  clk_i,
  input  wire                                  rst_ni,
  input  wire                                  req_i   [sdram_geom_pkg::PORTS],
  input  wire                                  we_i    [sdram_geom_pkg::PORTS],
  input  wire  [sdram_geom_pkg::BA_BITS-1:0]   ba_i    [sdram_geom_pkg::PORTS],
  input  wire  [sdram_geom_pkg::ROW_BITS-1:0]  row_i   [sdram_geom_pkg::PORTS],
  input  wire  [sdram_geom_pkg::COL_BITS-1:0]  col_i   [sdram_geom_pkg::PORTS],
  input  wire  [sdram_geom_pkg::DQ_BITS-1:0]   wdata_i [sdram_geom_pkg::PORTS],
  output logic                                 rdy_o   [sdram_geom_pkg::PORTS],
  sched_req_if.arbiter                         req
);
  import sdram_geom_pkg::*;

  logic [PORTS-1:0]     req_m;
  logic [PORT_BITS-1:0] sel;

  // A port in its ready cycle is already served
  always_comb
  begin
    for (int p = 0; p < PORTS; p++)
      req_m[p] = req_i[p] & ~rdy_o[p];
  end

  // Port 0 wins, so scan downwards and keep the last hit
  always_comb
  begin
    sel = '0;
    for (int p = PORTS - 1; p >= 0; p--)
      if (req_m[p])
        sel = PORT_BITS'(p);
  end

  assign req.valid = |req_m;
  assign req.port  = sel;
  assign req.we    = we_i[sel];
  assign req.ba    = ba_i[sel];
  assign req.row   = row_i[sel];
  assign req.col   = col_i[sel];
  assign req.wdata = wdata_i[sel];

  // One-cycle ready, lines up with the RD/WR on the bus
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      for (int p = 0; p < PORTS; p++)
        rdy_o[p] <= 1'b0;
    end
    else
    begin
      for (int p = 0; p < PORTS; p++)
        rdy_o[p] <= req.issue && (sel == PORT_BITS'(p));
    end
  end

endmodule : port_arbiter

`default_nettype wire

//--- hw/read_return.sv
`timescale 1ns/1ps
`default_nettype none

module read_return (
  input  wire                                  clk_i,
  input  wire                                  rst_ni,
  input  wire                                  rd_issue_i,
  input  wire  [sdram_geom_pkg::PORT_BITS-1:0] rd_port_i,
  input  wire  [sdram_geom_pkg::DQ_BITS-1:0]   sdram_dq_i,
  output logic [sdram_geom_pkg::DQ_BITS-1:0]   rdq_o,
  output logic                                 rdqvalid_o [sdram_geom_pkg::PORTS]
);
  import sdram_geom_pkg::*;
  import sdram_timing_pkg::*;

  // Stage 0 is the newest read, stage CAS_LAT meets its data on the bus
  logic [CAS_LAT:0]     vld_q;
  logic [PORT_BITS-1:0] port_q [CAS_LAT+1];

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      vld_q <= '0;
      for (int p = 0; p < PORTS; p++)
        rdqvalid_o[p] <= 1'b0;
    end
    else
    begin
      vld_q <= {vld_q[CAS_LAT-1:0], rd_issue_i};
      for (int p = 0; p < PORTS; p++)
        rdqvalid_o[p] <= vld_q[CAS_LAT] && (port_q[CAS_LAT] == PORT_BITS'(p));
    end
  end

  always_ff @(posedge clk_i)
  begin
    port_q[0] <= rd_port_i;
    for (int i = 1; i <= CAS_LAT; i++)
      port_q[i] <= port_q[i-1];
    rdq_o <= sdram_dq_i;
  end

endmodule : read_return

`default_nettype wire

//--- hw/refresh_timer.sv
`timescale 1ns/1ps
`default_nettype none

module refresh_timer (
  input  wire   clk_i,
  input  wire   rst_ni,
  input  wire   ref_issue_i,
  output logic  ref_due_o,
  output logic  ref_urgent_o,
  output logic  rfc_ok_o
);
  import sdram_timing_pkg::*;

  logic [REFI_BITS-1:0] refi_cnt;
  logic                 expire;
  logic [PEND_BITS-1:0] pend;
  logic [PEND_BITS-1:0] pend_eff;
  logic [TCNT_BITS-1:0] rfc_cnt;

  assign expire = (refi_cnt == '0);

  // Expiry counts as pending in the same cycle
  assign pend_eff     = pend + PEND_BITS'(expire);
  assign ref_due_o    = (pend_eff != '0);
  assign ref_urgent_o = (pend_eff >= PEND_BITS'(REF_PEND_MAX));
  assign rfc_ok_o     = (rfc_cnt == '0);

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      refi_cnt <= REFI_BITS'(T_REFI - 1);
      pend     <= '0;
      rfc_cnt  <= '0;
    end
    else
    begin
      refi_cnt <= expire ? REFI_BITS'(T_REFI - 1) : refi_cnt - 1'b1;

      // Expiry and service together leave the count alone
      case ({expire, ref_issue_i})
        2'b10:   pend <= pend + 1'b1;
        2'b01:   pend <= pend - 1'b1;
        default: pend <= pend;
      endcase

      if (ref_issue_i)
        rfc_cnt <= TCNT_BITS'(T_RFC);
      else if (!rfc_ok_o)
        rfc_cnt <= rfc_cnt - 1'b1;
    end
  end

endmodule : refresh_timer

`default_nettype wire

//--- hw/sdram_geom_pkg.sv
`default_nettype none

package sdram_geom_pkg;

  // Requester side
  localparam int PORTS     = 2;
  localparam int PORT_BITS = $clog2(PORTS);

  // SDRAM geometry
  localparam int BA_BITS   = 2;
  localparam int BANKS     = 1 << BA_BITS;
  localparam int ROW_BITS  = 11;
  localparam int COL_BITS  = 8;
  localparam int ADDR_BITS = 11;
  localparam int DQ_BITS   = 16;

  // Address bit that turns PRE into PRE-all
  localparam int AP_BIT    = 10;

  // Command encoding is {RAS_n, CAS_n, WE_n}
  typedef enum logic [2:0] {
    CMD_NOP = 3'b111,
    CMD_ACT = 3'b011,
    CMD_RD  = 3'b101,
    CMD_WR  = 3'b100,
    CMD_PRE = 3'b010,
    CMD_REF = 3'b001
  } sdram_cmd_t;

endpackage : sdram_geom_pkg

`default_nettype wire

//--- hw/sdram_sched_if.sv
`timescale 1ns/1ps
`default_nettype none

// Selected request towards the command sequencer
interface sched_req_if;
  import sdram_geom_pkg::*;

  logic                 valid;
  logic                 we;
  logic [PORT_BITS-1:0] port;
  logic [BA_BITS-1:0]   ba;
  logic [ROW_BITS-1:0]  row;
  logic [COL_BITS-1:0]  col;
  logic [DQ_BITS-1:0]   wdata;
  logic                 issue;

  modport arbiter   (output valid, we, port, ba, row, col, wdata, input issue);
  modport sequencer (input valid, we, port, ba, row, col, wdata, output issue);
endinterface : sched_req_if

// Bank commands in, per-bank state out
interface bank_if;
  import sdram_geom_pkg::*;

  logic                act;
  logic                pre;
  logic                pre_all;
  logic [BA_BITS-1:0]  ba;
  logic [ROW_BITS-1:0] row;
  logic [BANKS-1:0]    open;
  logic [ROW_BITS-1:0] open_row [BANKS];
  logic [BANKS-1:0]    act_ok;
  logic [BANKS-1:0]    rw_ok;
  logic [BANKS-1:0]    pre_ok;

  modport sequencer (output act, pre, pre_all, ba, row,
                     input open, open_row, act_ok, rw_ok, pre_ok);
  modport tracker   (input act, pre, pre_all, ba, row,
                     output open, open_row, act_ok, rw_ok, pre_ok);
endinterface : bank_if

`default_nettype wire

//--- hw/sdram_sched_top.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_sched_top (
  input  wire                                   clk_i,
  input  wire                                   rst_ni,
  input  wire                                   req_i      [sdram_geom_pkg::PORTS],
  input  wire                                   we_i       [sdram_geom_pkg::PORTS],
  input  wire  [sdram_geom_pkg::BA_BITS-1:0]    ba_i       [sdram_geom_pkg::PORTS],
  input  wire  [sdram_geom_pkg::ROW_BITS-1:0]   row_i      [sdram_geom_pkg::PORTS],
  input  wire  [sdram_geom_pkg::COL_BITS-1:0]   col_i      [sdram_geom_pkg::PORTS],
  input  wire  [sdram_geom_pkg::DQ_BITS-1:0]    wdata_i    [sdram_geom_pkg::PORTS],
  output logic                                  rdy_o      [sdram_geom_pkg::PORTS],
  output logic [sdram_geom_pkg::DQ_BITS-1:0]    rdq_o,
  output logic                                  rdqvalid_o [sdram_geom_pkg::PORTS],
  output sdram_geom_pkg::sdram_cmd_t            sdram_cmd_o,
  output logic [sdram_geom_pkg::BA_BITS-1:0]    sdram_ba_o,
  output logic [sdram_geom_pkg::ADDR_BITS-1:0]  sdram_addr_o,
  output logic [sdram_geom_pkg::DQ_BITS-1:0]    sdram_dq_o,
  output logic                                  sdram_dqoe_o,
  input  wire  [sdram_geom_pkg::DQ_BITS-1:0]    sdram_dq_i
);
  import sdram_geom_pkg::*;

  logic                 ref_due;
  logic                 ref_urgent;
  logic                 ref_issue;
  logic                 rfc_ok;
  logic                 rd_issue;
  logic [PORT_BITS-1:0] rd_port;

  sched_req_if u_req_if ();
  bank_if      u_bank_if ();

  port_arbiter u_port_arbiter (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (req_i),
    .we_i    (we_i),
    .ba_i    (ba_i),
    .row_i   (row_i),
    .col_i   (col_i),
    .wdata_i (wdata_i),
    .rdy_o   (rdy_o),
    .req     (u_req_if.arbiter)
  );

  bank_tracker u_bank_tracker (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .bank   (u_bank_if.tracker)
  );

  refresh_timer u_refresh_timer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .ref_issue_i  (ref_issue),
    .ref_due_o    (ref_due),
    .ref_urgent_o (ref_urgent),
    .rfc_ok_o     (rfc_ok)
  );

  cmd_sequencer u_cmd_sequencer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req          (u_req_if.sequencer),
    .bank         (u_bank_if.sequencer),
    .ref_due_i    (ref_due),
    .ref_urgent_i (ref_urgent),
    .rfc_ok_i     (rfc_ok),
    .ref_issue_o  (ref_issue),
    .rd_issue_o   (rd_issue),
    .rd_port_o    (rd_port),
    .sdram_cmd_o  (sdram_cmd_o),
    .sdram_ba_o   (sdram_ba_o),
    .sdram_addr_o (sdram_addr_o),
    .sdram_dq_o   (sdram_dq_o),
    .sdram_dqoe_o (sdram_dqoe_o)
  );

  read_return u_read_return (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rd_issue_i (rd_issue),
    .rd_port_i  (rd_port),
    .sdram_dq_i (sdram_dq_i),
    .rdq_o      (rdq_o),
    .rdqvalid_o (rdqvalid_o)
  );

endmodule : sdram_sched_top

`default_nettype wire

//--- hw/sdram_timing_pkg.sv
`default_nettype none

package sdram_timing_pkg;

  // All values in clock cycles
  localparam int T_RCD        = 2;
  localparam int T_RP         = 2;
  localparam int T_RAS        = 5;
  localparam int T_RFC        = 7;
  localparam int CAS_LAT      = 2;
  localparam int T_REFI       = 200;
  localparam int REF_PEND_MAX = 4;

  // Counter widths
  localparam int TCNT_MAX  = (T_RAS > T_RFC) ? T_RAS : T_RFC;
  localparam int TCNT_BITS = $clog2(TCNT_MAX + 1);
  localparam int REFI_BITS = $clog2(T_REFI);
  localparam int PEND_BITS = $clog2(REF_PEND_MAX + 1) + 1;

endpackage : sdram_timing_pkg

`default_nettype wire

//--- sdram_sched_top.f
hw/sdram_geom_pkg.sv
hw/sdram_timing_pkg.sv
hw/sdram_sched_if.sv
hw/port_arbiter.sv
hw/bank_tracker.sv
hw/refresh_timer.sv
hw/cmd_sequencer.sv
hw/read_return.sv
hw/sdram_sched_top.sv
sim/sdram_sched_tb.sv

//--- sim/sdram_sched_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_sched_tb;
  import sdram_geom_pkg::*;
  import sdram_timing_pkg::*;

  localparam int N_TRANS    = 400;
  localparam int MAX_CYCLES = N_TRANS * 60;
  localparam int KEY_BITS   = BA_BITS + ROW_BITS + COL_BITS;
  localparam int MEM_WORDS  = 1 << KEY_BITS;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 req      [PORTS];
  logic                 we       [PORTS];
  logic [BA_BITS-1:0]   ba       [PORTS];
  logic [ROW_BITS-1:0]  row      [PORTS];
  logic [COL_BITS-1:0]  col      [PORTS];
  logic [DQ_BITS-1:0]   wdata    [PORTS];
  logic                 rdy      [PORTS];
  logic [DQ_BITS-1:0]   rdq;
  logic                 rdqvalid [PORTS];
  sdram_cmd_t           sdram_cmd;
  logic [BA_BITS-1:0]   sdram_ba;
  logic [ADDR_BITS-1:0] sdram_addr;
  logic [DQ_BITS-1:0]   sdram_dq_out;
  logic                 sdram_dqoe;
  logic [DQ_BITS-1:0]   sdram_dq_in;

  // Stimulus and bookkeeping
  logic [31:0] lfsr;
  int          cycle;
  int          issued;
  int          presented;
  int          ref_cnt;
  int          served_cnt [PORTS];
  int          taken_cnt  [PORTS];
  bit          prev_req0;
  bit          prev_rdy0;

  // Behavioral SDRAM state
  logic [DQ_BITS-1:0]  mem_data    [MEM_WORDS];
  bit                  mem_wr      [MEM_WORDS];
  bit                  bank_open_m [BANKS];
  logic [ROW_BITS-1:0] open_row_m  [BANKS];
  int                  last_act    [BANKS];
  int                  last_pre    [BANKS];
  int                  last_ref;
  // Entry i is the read data for i+1 cycles ahead
  logic [DQ_BITS-1:0]  dq_pipe     [CAS_LAT];

  // Reference memory and reads in flight
  logic [DQ_BITS-1:0]  ref_data [MEM_WORDS];
  bit                  ref_wr   [MEM_WORDS];
  int                  exp_port [$];
  logic [DQ_BITS-1:0]  exp_data [$];
  int                  exp_due  [$];

  sdram_sched_top DUT (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req),
    .we_i         (we),
    .ba_i         (ba),
    .row_i        (row),
    .col_i        (col),
    .wdata_i      (wdata),
    .rdy_o        (rdy),
    .rdq_o        (rdq),
    .rdqvalid_o   (rdqvalid),
    .sdram_cmd_o  (sdram_cmd),
    .sdram_ba_o   (sdram_ba),
    .sdram_addr_o (sdram_addr),
    .sdram_dq_o   (sdram_dq_out),
    .sdram_dqoe_o (sdram_dqoe),
    .sdram_dq_i   (sdram_dq_in)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp,
                          input string what);
    if (got !== exp)
    begin
      $display("Fail at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic int mem_key(input logic [BA_BITS-1:0]  b,
                                 input logic [ROW_BITS-1:0] r,
                                 input logic [COL_BITS-1:0] c);
    return int'({b, r, c});
  endfunction

  // Power-up content, every address bit takes part
  function automatic logic [DQ_BITS-1:0] init_word(input int key);
    return DQ_BITS'(key) ^ DQ_BITS'(key >> DQ_BITS) ^ 16'hc3a5;
  endfunction

  // Last write to the address in issue order, else the power-up word
  function automatic logic [DQ_BITS-1:0] expected_read(input int key);
    if (ref_wr[key])
      return ref_data[key];
    return init_word(key);
  endfunction

  // Next request of one port, or a one-cycle gap now and then
  task next_request(input int p);
    logic [31:0] r;
    if (presented == N_TRANS)
      req[p] <= 1'b0;
    else
    begin
      take_bits(3, r);
      if (req[p] && r[2:0] == 3'd0)
        req[p] <= 1'b0;
      else
      begin
        presented++;
        req[p] <= 1'b1;
        take_bits(1, r);
        we[p] <= r[0];
        take_bits(BA_BITS, r);
        ba[p] <= r[BA_BITS-1:0];
        // Four rows only, so hits and misses both occur
        take_bits(2, r);
        row[p] <= {r[1:0], 7'h00, r[1:0]};
        take_bits(3, r);
        col[p] <= {5'h00, r[2:0]};
        take_bits(DQ_BITS, r);
        wdata[p] <= r[DQ_BITS-1:0];
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // SDRAM model with protocol checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic model_command();
    int b;
    int key;
    b = int'(sdram_ba);
    for (int i = 0; i < CAS_LAT - 1; i++)
      dq_pipe[i] = dq_pipe[i+1];
    dq_pipe[CAS_LAT-1] = '0;
    case (sdram_cmd)
      CMD_ACT:
      begin
        check_eq(bank_open_m[b], 0, "ACT to an open bank");
        check_eq(cycle - last_pre[b] >= T_RP, 1, "tRP before ACT");
        check_eq(cycle - last_ref >= T_RFC, 1, "tRFC before ACT");
        bank_open_m[b] = 1'b1;
        open_row_m[b]  = sdram_addr[ROW_BITS-1:0];
        last_act[b]    = cycle;
      end
      CMD_RD, CMD_WR:
      begin
        check_eq(bank_open_m[b], 1, "RD/WR to a closed bank");
        check_eq(cycle - last_act[b] >= T_RCD, 1, "tRCD before RD/WR");
        key = mem_key(sdram_ba, open_row_m[b], sdram_addr[COL_BITS-1:0]);
        if (sdram_cmd == CMD_WR)
        begin
          mem_data[key] = sdram_dq_out;
          mem_wr[key]   = 1'b1;
        end
        else
          dq_pipe[CAS_LAT-1] = mem_wr[key] ? mem_data[key] : init_word(key);
      end
      CMD_PRE:
        for (int i = 0; i < BANKS; i++)
          if (sdram_addr[AP_BIT] || i == b)
          begin
            if (bank_open_m[i])
              check_eq(cycle - last_act[i] >= T_RAS, 1, "tRAS before PRE");
            bank_open_m[i] = 1'b0;
            last_pre[i]    = cycle;
          end
      CMD_REF:
      begin
        for (int i = 0; i < BANKS; i++)
        begin
          check_eq(bank_open_m[i], 0, "REF with a bank open");
          check_eq(cycle - last_pre[i] >= T_RP, 1, "tRP before REF");
        end
        check_eq(cycle - last_ref >= T_RFC, 1, "tRFC before REF");
        last_ref = cycle;
        ref_cnt++;
      end
      default:
        check_eq(sdram_cmd, CMD_NOP, "unknown SDRAM command");
    endcase
  endtask

  // Read data goes out in the cycle after the model's edge
  always @(posedge clk_i)
    sdram_dq_in <= dq_pipe[0];

  ////////////////////////////////////////////////////////////////////////////
  // Comparison
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_return();
    logic [PORTS-1:0] got_v;
    logic [PORTS-1:0] exp_v;
    bit               due;
    due   = (exp_due.size() != 0) && (exp_due[0] == cycle);
    exp_v = '0;
    if (due)
      exp_v[exp_port[0]] = 1'b1;
    for (int p = 0; p < PORTS; p++)
      got_v[p] = rdqvalid[p];
    check_eq(got_v, exp_v, "rdqvalid pattern");
    if (due)
    begin
      check_eq(rdq, exp_data[0], "read data");
      void'(exp_port.pop_front());
      void'(exp_data.pop_front());
      void'(exp_due.pop_front());
    end
  endtask

  task automatic check_ready();
    int n;
    int key;
    n = 0;
    for (int p = 0; p < PORTS; p++)
      if (rdy[p])
      begin
        n++;
        check_eq(sdram_cmd, we[p] ? CMD_WR : CMD_RD, "command at ready");
        check_eq(sdram_ba, ba[p], "bank at ready");
        check_eq(sdram_addr, ADDR_BITS'(col[p]), "column at ready");
        check_eq(open_row_m[ba[p]], row[p], "open row at ready");
        key = mem_key(ba[p], row[p], col[p]);
        if (we[p])
        begin
          check_eq(sdram_dq_out, wdata[p], "write data");
          ref_data[key] = wdata[p];
          ref_wr[key]   = 1'b1;
        end
        else
        begin
          exp_port.push_back(p);
          exp_data.push_back(expected_read(key));
          exp_due.push_back(cycle + CAS_LAT + 1);
        end
        served_cnt[p]++;
        issued++;
      end
    check_eq(n, (sdram_cmd == CMD_RD || sdram_cmd == CMD_WR) ? 1 : 0,
             "ready pulses per RD/WR");
    check_eq(sdram_dqoe, sdram_cmd == CMD_WR, "dqoe outside WR");
    // Port 1 wins only when port 0 was quiet or just served
    if (rdy[1])
      check_eq(!prev_req0 || prev_rdy0, 1, "port 0 priority");
  endtask

  always @(negedge clk_i)
  begin
    if (!rst_ni)
    begin
      check_eq(sdram_cmd, CMD_NOP, "command in reset");
      check_eq(sdram_dqoe, 0, "dqoe in reset");
      for (int p = 0; p < PORTS; p++)
      begin
        check_eq(rdy[p], 0, "rdy in reset");
        check_eq(rdqvalid[p], 0, "rdqvalid in reset");
      end
    end
    else
    begin
      cycle++;
      if (cycle > MAX_CYCLES)
      begin
        $display("Timeout after %0d cycles, %0d of %0d transactions served",
                 cycle, issued, N_TRANS);
        $display("Something failed");
        $fatal(1);
      end
      check_return();
      model_command();
      check_ready();
      prev_req0 = req[0];
      prev_rdy0 = rdy[0];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    lfsr        = 32'he987_f0c6;
    rst_ni      = 1'b0;
    sdram_dq_in = '0;
    cycle       = 0;
    issued      = 0;
    presented   = 0;
    ref_cnt     = 0;
    last_ref    = -100;
    prev_req0   = 1'b0;
    prev_rdy0   = 1'b0;
    for (int p = 0; p < PORTS; p++)
    begin
      req[p]        = 1'b0;
      we[p]         = 1'b0;
      ba[p]         = '0;
      row[p]        = '0;
      col[p]        = '0;
      wdata[p]      = '0;
      served_cnt[p] = 0;
      taken_cnt[p]  = 0;
    end
    for (int b = 0; b < BANKS; b++)
    begin
      bank_open_m[b] = 1'b0;
      open_row_m[b]  = '0;
      last_act[b]    = -100;
      last_pre[b]    = -100;
    end
    for (int i = 0; i < CAS_LAT; i++)
      dq_pipe[i] = '0;

    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;

    while (issued < N_TRANS || exp_due.size() != 0)
    begin
      @(posedge clk_i);
      for (int p = 0; p < PORTS; p++)
        if (!req[p] || served_cnt[p] != taken_cnt[p])
        begin
          taken_cnt[p] = served_cnt[p];
          next_request(p);
        end
    end

    check_eq(ref_cnt >= cycle / T_REFI - REF_PEND_MAX, 1, "too few REF commands");
    $display("Everything OK");
    $finish;
  end

endmodule : sdram_sched_tb

`default_nettype wire
